// ==== list.f ====
+incdir+hdl
hdl/video_pkg.sv
hdl/raster_counter.sv
hdl/sync_shaper.sv
hdl/layer_window.sv
hdl/fetch_arbiter.sv
hdl/video_raster_top.sv
tests/tb_video_raster.sv

// ==== run.sh ====
#!/bin/sh
# build the raster testbench with verilator, run it, look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module tb_video_raster -o tb_video_raster
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/tb_video_raster)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -q '^RESULT: PASS$'; then
	exit 0
fi
echo "pass line not found in simulation output"
exit 1

// ==== tests/tb_video_raster.sv ====
`timescale 1ns/1ps
`include "video_settings.svh"

module tb_video_raster
	import video_pkg::*;
();

	localparam int N_CASES = 3;
	localparam int FRAME_CLKS = `HPERIOD * `VPERIOD;

	// one row of the stimulus table
	typedef struct packed
	{
		window_cfg_t [`N_LAYERS-1:0] win;
		logic [7:0] hint_col;
		logic [8:0] hint_line;
		// one enable per pair of clocks
		// slot in the pair drawn at random
		logic ce_random;
		logic [4:0] frames;
		// line of the mid frame row write
		logic [8:0] wr_line;
	} case_t;

	logic clk;
	logic reset;
	logic pix_ce;
	logic [7:0] hint_col;
	logic [8:0] hint_line;
	window_cfg_t cfg [`N_LAYERS];
	logic [`N_LAYERS-1:0] row_wr;
	logic hsync;
	logic vsync;
	logic csync;
	logic tv_blank;
	logic int_start;
	logic frame;
	logic flash;
	logic video_go;
	logic any_visible;
	logic pix_start;
	logic [1:0] go_layer;
	logic [8:0] rows [`N_LAYERS];

	case_t cases [N_CASES];
	string case_names [N_CASES];
	case_t cur;
	string cur_name;

	// reference model of the raster
	int m_h;
	int m_v;
	int m_frames;
	int ce_steps;
	int int_count;
	int pix_count;
	logic [8:0] m_row [`N_LAYERS];
	logic [`N_LAYERS-1:0] m_pend;
	logic [`N_LAYERS-1:0] wr_cur;
	// expected registered outputs for the next clock
	logic e_hsync;
	logic e_vsync;
	logic e_csync;
	logic e_blank;
	logic e_pix_start;
	logic ce_cur;
	logic wr_done;
	logic pair_phase;
	logic pair_slot;
	logic [31:0] rng;
	int cycles = 0;
	int limit;

	video_raster_top dut (.*);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// hard stop
	always @(posedge clk)
	begin
		cycles = cycles + 1;
		if (cycles > limit)
		begin
			$display("timeout: simulation ran past %0d clocks", limit);
			$display("RESULT: FAIL");
			$fatal(1, "timeout");
		end
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		return x ^ (x << 5);
	endfunction

	function automatic window_cfg_t make_window(input int hb, input int he, input int vb,
		input int ve, input int rs, input logic en);
		window_cfg_t w;
		w.hbeg = 9'(hb);
		w.hend = 9'(he);
		w.vbeg = 9'(vb);
		w.vend = 9'(ve);
		w.rstart = 9'(rs);
		w.enable = en;
		return w;
	endfunction

	function automatic case_t make_case(input window_cfg_t w0, input window_cfg_t w1,
		input window_cfg_t w2, input int col, input int line, input logic rnd,
		input int frames, input int wr_line);
		case_t c;
		c.win[0] = w0;
		c.win[1] = w1;
		c.win[2] = w2;
		c.hint_col = 8'(col);
		c.hint_line = 9'(line);
		c.ce_random = rnd;
		c.frames = 5'(frames);
		c.wr_line = 9'(wr_line);
		return c;
	endfunction

	// window line range without the enable
	function automatic logic on_lines(input window_cfg_t w, input int v);
		return v >= int'(w.vbeg) && v < int'(w.vend);
	endfunction

	function automatic logic shows(input window_cfg_t w, input int h, input int v);
		return w.enable && on_lines(w, v) && h >= int'(w.hbeg) && h < int'(w.hend);
	endfunction

	// fetch columns sit FETCH_LEAD ahead of the visible ones
	function automatic logic fetches(input window_cfg_t w, input int h, input int v);
		return w.enable && on_lines(w, v)
			&& h >= int'(w.hbeg) - `FETCH_LEAD && h < int'(w.hend) - `FETCH_LEAD;
	endfunction

	function automatic int first_enabled(input case_t c);
		for (int i = 0; i < `N_LAYERS; i++)
			if (c.win[i].enable)
				return i;
		return -1;
	endfunction

	task automatic check(input string what, input int expected, input int actual);
		assert (expected == actual)
		else
		begin
			$display("MISMATCH %s %s expected %0d actual %0d", cur_name, what, expected, actual);
			$display("RESULT: FAIL");
			$fatal(1, "output mismatch");
		end
	endtask

	// compare every output at mid period
	task automatic check_outputs();
		logic exp_vis;
		logic exp_go;
		int exp_layer;
		exp_vis = 1'b0;
		exp_go = 1'b0;
		exp_layer = 0;
		check("hsync", int'(e_hsync), int'(hsync));
		check("vsync", int'(e_vsync), int'(vsync));
		check("csync", int'(e_csync), int'(csync));
		check("tv_blank", int'(e_blank), int'(tv_blank));
		// highest index first so the lowest requester ends up in exp_layer
		for (int i = `N_LAYERS - 1; i >= 0; i--)
		begin
			if (fetches(cur.win[i], m_h, m_v))
			begin
				exp_go = 1'b1;
				exp_layer = i;
			end
			exp_vis = exp_vis | shows(cur.win[i], m_h, m_v);
			check($sformatf("row %0d", i), int'(m_row[i]), int'(rows[i]));
		end
		check("any_visible", int'(exp_vis), int'(any_visible));
		check("video_go", int'(exp_go), int'(video_go));
		check("go_layer", exp_layer, int'(go_layer));
		check("int_start", int'(ce_cur && m_h == 2 * int'(cur.hint_col)
			&& m_v == int'(cur.hint_line)), int'(int_start));
		check("frame", m_frames % 2, int'(frame));
		// flash flips once every 16 frames
		check("flash", (m_frames / 16) % 2, int'(flash));
		check("pix_start", int'(e_pix_start), int'(pix_start));
		if (int_start)
			int_count++;
		if (pix_start)
			pix_count++;
	endtask

	// model step on the rising edge from the old position and enable
	task automatic advance_model();
		logic hs;
		logic vs;
		logic step;
		int lead;
		int next_v;
		hs = m_h >= `HSYNC_BEG && m_h < `HSYNC_END;
		vs = m_v >= `VSYNC_BEG && m_v < `VSYNC_END;
		e_hsync = !hs;
		e_vsync = !vs;
		e_csync = !(hs ^ vs);
		e_blank = (m_h >= 1 && m_h <= `HBLNK_END) || m_v < `VBLNK_END;
		lead = first_enabled(cur);
		e_pix_start = 1'b0;
		if (lead >= 0)
			e_pix_start = ce_cur && on_lines(cur.win[lead], m_v)
				&& m_h == int'(cur.win[lead].hbeg) - 1;
		step = ce_cur && m_h == `HPERIOD - 1;
		next_v = (m_v + 1) % `VPERIOD;
		for (int i = 0; i < `N_LAYERS; i++)
		begin
			// reload ahead of the first window line or after a write
			if (step && (next_v == int'(cur.win[i].vbeg) || m_pend[i]))
				m_row[i] = cur.win[i].rstart;
			else if (step && on_lines(cur.win[i], m_v))
				m_row[i] = m_row[i] + 9'd1;
			if (wr_cur[i])
				m_pend[i] = 1'b1;
			else if (step)
				m_pend[i] = 1'b0;
		end
		if (ce_cur)
		begin
			ce_steps++;
			m_h = step ? 0 : m_h + 1;
			if (step)
				m_v = next_v;
			if (step && next_v == 0)
				m_frames++;
		end
	endtask

	task automatic drive_inputs();
		logic [`N_LAYERS-1:0] wr;
		wr = '0;
		// single row write per case at column 200
		if (!wr_done && m_h == 200 && m_v == int'(cur.wr_line))
		begin
			wr = '1;
			wr_done = 1'b1;
		end
		if (cur.ce_random && !pair_phase)
		begin
			rng = xorshift(rng);
			pair_slot = rng[0];
		end
		ce_cur = !cur.ce_random || (pair_phase == pair_slot);
		pair_phase = cur.ce_random && !pair_phase;
		wr_cur = wr;
		pix_ce <= ce_cur;
		row_wr <= wr;
	endtask

	task automatic run_case(input int k);
		int lead;
		cur = cases[k];
		cur_name = case_names[k];
		@(posedge clk);
		reset <= 1'b1;
		pix_ce <= 1'b0;
		row_wr <= '0;
		hint_col <= cur.hint_col;
		hint_line <= cur.hint_line;
		for (int i = 0; i < `N_LAYERS; i++)
			cfg[i] <= cur.win[i];
		repeat (3) @(posedge clk);
		reset <= 1'b0;
		// model back at position zero with syncs idle
		m_h = 0;
		m_v = 0;
		m_frames = 0;
		ce_steps = 0;
		int_count = 0;
		pix_count = 0;
		m_pend = '0;
		wr_done = 1'b0;
		pair_phase = 1'b0;
		for (int i = 0; i < `N_LAYERS; i++)
			m_row[i] = '0;
		{e_hsync, e_vsync, e_csync, e_blank, e_pix_start} = 5'b11110;
		drive_inputs();
		while (ce_steps < int'(cur.frames) * FRAME_CLKS)
		begin
			@(negedge clk);
			check_outputs();
			@(posedge clk);
			advance_model();
			drive_inputs();
		end
		lead = first_enabled(cur);
		check("int_start pulses", int'(cur.frames), int_count);
		check("pix_start pulses", int'(cur.frames)
			* (int'(cur.win[lead].vend) - int'(cur.win[lead].vbeg)), pix_count);
		@(negedge clk);
		check("flash at end", (m_frames / 16) % 2, int'(flash));
		$display("case %s done after %0d frames", cur_name, m_frames);
	endtask

	initial
	begin
		reset <= 1'b1;
		pix_ce <= 1'b0;
		hint_col <= '0;
		hint_line <= '0;
		row_wr <= '0;
		for (int i = 0; i < `N_LAYERS; i++)
			cfg[i] <= '0;
		rng = 32'd59351;
		// graphics and one tile plane overlap
		// third plane off
		case_names[0] = "two_planes";
		cases[0] = make_case(make_window(100, 356, 40, 240, 5, 1'b1),
			make_window(96, 400, 32, 300, 100, 1'b1),
			make_window(10, 30, 0, 320, 0, 1'b0), 60, 50, 1'b0, 1, 120);
		// tile planes only with the interrupt near the frame end
		case_names[1] = "random_ce";
		cases[1] = make_case(make_window(100, 200, 40, 80, 9, 1'b0),
			make_window(120, 200, 50, 100, 300, 1'b1),
			make_window(8, 440, 60, 319, 7, 1'b1), 223, 319, 1'b1, 1, 70);
		case_names[2] = "flash_17_frames";
		cases[2] = make_case(make_window(88, 408, 32, 288, 0, 1'b1),
			make_window(150, 300, 100, 200, 20, 1'b0),
			make_window(200, 260, 0, 10, 500, 1'b1), 0, 0, 1'b0, 17, 200);
		// clocks of all cases plus reset and slack
		limit = 1000;
		for (int k = 0; k < N_CASES; k++)
			limit += int'(cases[k].frames) * FRAME_CLKS * (cases[k].ce_random ? 2 : 1) + 16;
		for (int k = 0; k < N_CASES; k++)
			run_case(k);
		$display("RESULT: PASS");
		$finish;
	end

endmodule

// ==== hdl/video_raster_top.sv ====
`timescale 1ns/1ps
`include "video_settings.svh"

module video_raster_top
	import video_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic pix_ce,
	input logic [7:0] hint_col,
	input logic [8:0] hint_line,
	input window_cfg_t cfg [`N_LAYERS],
	input logic [`N_LAYERS-1:0] row_wr,
	output logic hsync,
	output logic vsync,
	output logic csync,
	output logic tv_blank,
	output logic int_start,
	output logic frame,
	output logic flash,
	output logic video_go,
	output logic [1:0] go_layer,
	output logic any_visible,
	output logic pix_start,
	output logic [8:0] rows [`N_LAYERS]
);

	// raster position broadcast
	raster_pos_t pos;
	// per layer results
	layer_status_t status [`N_LAYERS];

	raster_counter u_counter (
		.clk (clk),
		.reset (reset),
		.pix_ce (pix_ce),
		.hint_col (hint_col),
		.hint_line (hint_line),
		.pos (pos),
		.int_start (int_start),
		.frame (frame),
		.flash (flash)
	);

	sync_shaper u_sync (
		.clk (clk),
		.reset (reset),
		.pos (pos),
		.hsync (hsync),
		.vsync (vsync),
		.csync (csync),
		.tv_blank (tv_blank)
	);

	// graphics plane at 0, tile planes above
	for (genvar i = 0; i < `N_LAYERS; i++)
	begin : g_layer
		layer_window u_window (
			.clk (clk),
			.reset (reset),
			.pos (pos),
			.cfg (cfg[i]),
			.row_wr (row_wr[i]),
			.status (status[i])
		);

		// row out for the fetch address
		assign rows[i] = status[i].row;
	end

	fetch_arbiter u_arbiter (
		.clk (clk),
		.reset (reset),
		.pos (pos),
		.cfg (cfg),
		.status (status),
		.video_go (video_go),
		.any_visible (any_visible),
		.pix_start (pix_start),
		.go_layer (go_layer)
	);

endmodule

// ==== hdl/fetch_arbiter.sv ====
`timescale 1ns/1ps
`include "video_settings.svh"

module fetch_arbiter
	import video_pkg::*;
(
	input logic clk,
	input logic reset,
	input raster_pos_t pos,
	input window_cfg_t cfg [`N_LAYERS],
	input layer_status_t status [`N_LAYERS],
	output logic video_go,
	output logic any_visible,
	output logic pix_start,
	output logic [1:0] go_layer
);

	// lowest enabled layer and its window
	logic [8:0] sel_hbeg;
	logic sel_vpix;
	logic start_hit;

	// request merge
	// walk from the top so the lowest index wins
	always_comb
	begin
		video_go = 1'b0;
		any_visible = 1'b0;
		go_layer = 2'd0;
		for (int i = `N_LAYERS - 1; i >= 0; i--)
		begin
			if (status[i].fetch_req)
				go_layer = 2'(i);
			video_go = video_go | status[i].fetch_req;
			any_visible = any_visible | status[i].visible;
		end
	end

	// pick the lowest enabled layer for the pixel start
	// with no layer enabled sel_vpix stays low
	always_comb
	begin
		sel_hbeg = '0;
		sel_vpix = 1'b0;
		for (int i = `N_LAYERS - 1; i >= 0; i--)
		begin
			if (cfg[i].enable)
			begin
				sel_hbeg = cfg[i].hbeg;
				// only on that layer's lines
				sel_vpix = (pos.vcount >= cfg[i].vbeg) & (pos.vcount < cfg[i].vend);
			end
		end
	end

	// column just before the first pixel
	assign start_hit = pos.pix_ce & sel_vpix
		& (pos.hcount == sel_hbeg - 9'd1);

	// one clock pulse after the hit
	always_ff @(posedge clk)
	begin
		if (reset)
			pix_start <= 1'b0;
		else
			pix_start <= start_hit;
	end

endmodule

// ==== hdl/layer_window.sv ====
`timescale 1ns/1ps
`include "video_settings.svh"

module layer_window
	import video_pkg::*;
(
	input logic clk,
	input logic reset,
	input raster_pos_t pos,
	input window_cfg_t cfg,
	input logic row_wr,
	output layer_status_t status
);

	// window range decodes
	logic hpix;
	logic vpix;
	logic hfetch;
	// column shifted by the fetch lead
	// one bit wider so it cannot wrap
	logic [9:0] hlead;
	// line number after the current line start
	logic [8:0] vnext;
	// current line ends just before the window
	logic first_line;
	// row strobe for this clock
	logic line_step;
	// deferred re-latch request
	logic relatch;
	logic [8:0] row;

	// visible columns and lines
	assign hpix = (pos.hcount >= cfg.hbeg) & (pos.hcount < cfg.hend);
	assign vpix = (pos.vcount >= cfg.vbeg) & (pos.vcount < cfg.vend);

	// fetch window
	// [hbeg - lead, hend - lead) written as column + lead
	assign hlead = {1'b0, pos.hcount} + 10'(`FETCH_LEAD);
	assign hfetch = (hlead >= {1'b0, cfg.hbeg}) & (hlead < {1'b0, cfg.hend});

	// next line with frame wrap
	assign vnext = (pos.vcount == 9'(`VPERIOD - 1)) ? 9'd0 : pos.vcount + 9'd1;
	assign first_line = (vnext == cfg.vbeg);

	// counters only move on qualified line starts
	assign line_step = pos.pix_ce & pos.line_start;

	// re-latch flag
	// set by the write strobe, consumed at the next line start
	always_ff @(posedge clk)
	begin
		if (reset)
			relatch <= 1'b0;
		else if (row_wr)
			relatch <= 1'b1;
		else if (line_step)
			relatch <= 1'b0;
	end

	// source row counter
	// load so that the first window line sees rstart
	// row tracks even while the layer is disabled
	always_ff @(posedge clk)
	begin
		if (reset)
			row <= '0;
		else if (line_step)
		begin
			if (first_line | relatch)
				row <= cfg.rstart;
			else if (vpix)
				row <= row + 9'd1;
		end
	end

	// status towards the arbiter
	always_comb
	begin
		status.visible = cfg.enable & hpix & vpix;
		status.fetch_req = cfg.enable & hfetch & vpix;
		status.row = row;
	end

endmodule

// ==== hdl/sync_shaper.sv ====
`timescale 1ns/1ps
`include "video_settings.svh"

module sync_shaper
	import video_pkg::*;
(
	input logic clk,
	input logic reset,
	input raster_pos_t pos,
	output logic hsync,
	output logic vsync,
	output logic csync,
	output logic tv_blank
);

	// active high sync terms
	logic hs;
	logic vs;
	// blank terms
	logic hblank;
	logic vblank;

	// horizontal sync range
	assign hs = (pos.hcount >= 9'(`HSYNC_BEG))
		& (pos.hcount < 9'(`HSYNC_END));

	// vertical sync range
	assign vs = (pos.vcount >= 9'(`VSYNC_BEG))
		& (pos.vcount < 9'(`VSYNC_END));

	// horizontal blank
	// column 0 is still active
	// blank runs 1..HBLNK_END
	assign hblank = (pos.hcount != 9'd0)
		& (pos.hcount <= 9'(`HBLNK_END));

	// top lines blanked
	assign vblank = (pos.vcount < 9'(`VBLNK_END));

	// registered outputs
	// syncs active low
	// reset values match the decode of position zero
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			hsync <= 1'b1;
			vsync <= 1'b1;
			csync <= 1'b1;
			tv_blank <= 1'b1;
		end
		else
		begin
			hsync <= ~hs;
			vsync <= ~vs;
			// serrated composite sync
			csync <= ~(hs ^ vs);
			tv_blank <= hblank | vblank;
		end
	end

endmodule

// ==== hdl/raster_counter.sv ====
`timescale 1ns/1ps
`include "video_settings.svh"

module raster_counter
	import video_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic pix_ce,
	input logic [7:0] hint_col,
	input logic [8:0] hint_line,
	output raster_pos_t pos,
	output logic int_start,
	output logic frame,
	output logic flash
);

	logic [8:0] hcount;
	logic [8:0] vcount;
	logic line_start;
	logic frame_start;
	// frame counter, bit 0 is frame and bit 4 is flash
	logic [4:0] flash_ctr;

	// last column and last line decodes
	assign line_start = (hcount == 9'(`HPERIOD - 1));
	assign frame_start = line_start & (vcount == 9'(`VPERIOD - 1));

	// horizontal counter
	// wraps on the last column
	always_ff @(posedge clk)
	begin
		if (reset)
			hcount <= '0;
		else if (pix_ce)
		begin
			if (line_start)
				hcount <= '0;
			else
				hcount <= hcount + 9'd1;
		end
	end

	// vertical counter
	// steps at the end of each line
	always_ff @(posedge clk)
	begin
		if (reset)
			vcount <= '0;
		else if (pix_ce & line_start)
		begin
			if (vcount == 9'(`VPERIOD - 1))
				vcount <= '0;
			else
				vcount <= vcount + 9'd1;
		end
	end

	// frame and flash toggles
	// one step per frame
	always_ff @(posedge clk)
	begin
		if (reset)
			flash_ctr <= '0;
		else if (pix_ce & frame_start)
			flash_ctr <= flash_ctr + 5'd1;
	end

	assign frame = flash_ctr[0];
	// toggles every 16 frames
	assign flash = flash_ctr[4];

	// raster interrupt
	// column given in half units, so doubled here
	assign int_start = pix_ce
		& (hcount == {hint_col, 1'b0})
		& (vcount == hint_line);

	// position broadcast
	always_comb
	begin
		pos.hcount = hcount;
		pos.vcount = vcount;
		pos.line_start = line_start;
		pos.frame_start = frame_start;
		pos.pix_ce = pix_ce;
	end

endmodule

// ==== hdl/video_pkg.sv ====
package video_pkg;

	// raster position as seen by every consumer
	// strobes are not qualified with pix_ce here
	typedef struct packed
	{
		// column within the line
		logic [8:0] hcount;
		// line within the frame
		logic [8:0] vcount;
		// last column of the line
		logic line_start;
		// last column of the last line
		logic frame_start;
		// pixel clock enable for the counters
		logic pix_ce;
	} raster_pos_t;

	// per layer window settings
	typedef struct packed
	{
		// first visible column
		logic [8:0] hbeg;
		// first column past the window
		logic [8:0] hend;
		// first visible line
		logic [8:0] vbeg;
		// first line past the window
		logic [8:0] vend;
		// source row loaded at window start
		logic [8:0] rstart;
		// layer on
		logic enable;
	} window_cfg_t;

	// per layer result towards the arbiter
	typedef struct packed
	{
		// inside the visible window
		logic visible;
		// fetch window, lead shifted
		logic fetch_req;
		// current source row
		logic [8:0] row;
	} layer_status_t;

endpackage

// ==== hdl/video_settings.svh ====
`ifndef VIDEO_SETTINGS_SVH
`define VIDEO_SETTINGS_SVH

// tv raster geometry in pixel clock periods
`define HPERIOD 448
// lines per frame
`define VPERIOD 320

// horizontal sync window in columns
`define HSYNC_BEG 11
`define HSYNC_END 43

// vertical sync window in lines
`define VSYNC_BEG 8
`define VSYNC_END 11

// last column of horizontal blank, counted from column 1
`define HBLNK_END 88
// lines below this one are blanked
`define VBLNK_END 32

// number of display layers
// layer 0 graphics, layers 1 and 2 tile planes
`define N_LAYERS 3

// columns the fetch runs ahead of the visible pixels
`define FETCH_LEAD 16

`endif
